/* Makefile */
# Verilator build and run for the trap and CSR unit

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing -f compile.f --top-module rv_trap_tb -o rv_trap_sim
	@out="$$(./obj_dir/rv_trap_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

/* compile.f */
+incdir+dv
logic/rv_trap_pkg.sv
logic/csr_state_if.sv
logic/irq_unit.sv
logic/excp_unit.sv
logic/trap_csr_file.sv
logic/rv_trap_top.sv
dv/rv_trap_tb.sv

/* dv/rv_trap_tests.svh */
// --------------------------------------------------
// directed tests for the trap and CSR unit
// --------------------------------------------------

// only the masked fields survive and MPP falls back to user unless it is machine
function automatic word_t mstatus_after_write(input word_t data);
    word_t v;
    v = data & 32'h0000_1888;
    if (v[12:11] != 2'b11) begin
        v[12:11] = 2'b00;
    end
    return v;
endfunction

task automatic do_mret(input word_t expected_addr);
    @(negedge clk_i);
    trap_rtn_i = 1'b1;
    #10;
    check("trap_rtn_addr_o", trap_rtn_addr_o, expected_addr);
    @(negedge clk_i);
    trap_rtn_i = 1'b0;
endtask

task automatic test_reset_state();
    int start;
    start = errors;
    check("mode_o", 32'(mode_o), 32'd3);
    check("jump_to_trap_o", 32'(jump_to_trap_o), 32'd0);
    check("interrupt_o", 32'(interrupt_o), 32'd0);
    check("rd_data_o", rd_data_o, 32'd0);
    check("bad_csr_addr_o", 32'(bad_csr_addr_o), 32'd0);
    check("readonly_csr_o", 32'(readonly_csr_o), 32'd0);
    check("priv_too_low_o", 32'(priv_too_low_o), 32'd0);
    read_check(csr_mtvec, "mtvec", 32'h0000_0100);
    read_check(csr_mvendorid, "mvendorid", 32'd0);
    check("bad_csr_addr_o", 32'(bad_csr_addr_o), 32'd0);
    read_check(csr_marchid, "marchid", 32'd0);
    check("bad_csr_addr_o", 32'(bad_csr_addr_o), 32'd0);
    read_check(csr_mimpid, "mimpid", 32'd0);
    check("bad_csr_addr_o", 32'(bad_csr_addr_o), 32'd0);
    read_check(csr_mhartid, "mhartid", 32'd0);
    check("bad_csr_addr_o", 32'(bad_csr_addr_o), 32'd0);
    finish_test("reset_state", start);
endtask

task automatic test_register_access();
    int    start;
    word_t d;
    start = errors;
    repeat (4) begin
        d = $random(seed);
        csr_write(csr_mscratch, d);
        read_check(csr_mscratch, "mscratch", d);
        d = $random(seed);
        csr_write(csr_mepc, d);
        read_check(csr_mepc, "mepc", d & 32'hFFFF_FFFC);
        d = $random(seed);
        csr_write(csr_mtvec, d);
        read_check(csr_mtvec, "mtvec", d & 32'hFFFF_FFFD);
        d = $random(seed);
        csr_write(csr_mie, d);
        read_check(csr_mie, "mie", d & 32'h0000_0888);
        d = $random(seed);
        csr_write(csr_mstatus, d);
        read_check(csr_mstatus, "mstatus", mstatus_after_write(d));
    end
    csr_write(csr_mstatus, 32'd0);
    csr_write(csr_mie, 32'd0);
    csr_write(csr_mtvec, 32'h0000_0100);
    csr_read(12'h7C0, d);
    check("bad_csr_addr_o", 32'(bad_csr_addr_o), 32'd1);
    csr_read(12'hF11, d);
    check("bad_csr_addr_o", 32'(bad_csr_addr_o), 32'd0);
    check("readonly_csr_o", 32'(readonly_csr_o), 32'd1);
    // stalled write must not land
    csr_write(csr_mscratch, 32'h1234_5678);
    @(negedge clk_i);
    exs_en_i  = 1'b0;
    wr_i      = 1'b1;
    wr_addr_i = csr_mscratch;
    wr_data_i = 32'hDEAD_BEEF;
    @(negedge clk_i);
    wr_i     = 1'b0;
    exs_en_i = 1'b1;
    read_check(csr_mscratch, "mscratch", 32'h1234_5678);
    finish_test("register_access", start);
endtask

task automatic test_exception_trap();
    int    start;
    int    k;
    word_t cause [6];
    word_t pc;
    word_t ins;
    word_t tval;
    start = errors;
    // ferr, ilgl, maif, mala, masa, ecall from machine mode
    cause = '{32'd1, 32'd2, 32'd0, 32'd4, 32'd6, 32'd11};
    csr_write(csr_mtvec, 32'h0000_0201);
    for (k = 0; k < 6; k++) begin
        csr_write(csr_mstatus, 32'h0000_0008);
        pc   = 32'h0000_1000 + 32'(16 * k);
        ins  = $random(seed);
        tval = (k == 1) ? ins : ((k >= 2 && k <= 4) ? pc : 32'd0);
        @(negedge clk_i);
        ex_valid_i = 1'b1;
        excp_pc_i  = pc;
        excp_ins_i = ins;
        // the chosen exception plus every one below it
        {excp_ferr_i, excp_ilgl_i, excp_maif_i, excp_mala_i, excp_masa_i, excp_ecall_i}
            = 6'b111111 >> k;
        wait_jump(4);
        check("trap_cause_o", trap_cause_o, cause[k]);
        check("trap_entry_addr_o", trap_entry_addr_o, 32'h0000_0200);
        @(negedge clk_i);
        idle_inputs();
        read_check(csr_mepc, "mepc", pc);
        read_check(csr_mcause, "mcause", cause[k]);
        read_check(csr_mtval, "mtval", tval);
        read_check(csr_mstatus, "mstatus", 32'h0000_1880);
    end
    csr_write(csr_mtvec, 32'h0000_0100);
    finish_test("exception_trap", start);
endtask

task automatic test_interrupts();
    int    start;
    int    lines;
    word_t exp_cause;
    start = errors;
    csr_write(csr_mtvec, 32'h0000_0200);
    csr_write(csr_mie, 32'h0000_0888);
    csr_write(csr_mstatus, 32'h0000_0008);
    for (lines = 0; lines < 8; lines++) begin
        @(negedge clk_i);
        {irq_extern_i, irq_softw_i, irq_timer_i} = 3'(lines);
        #10;
        exp_cause = lines[2] ? 32'h8000_000B : (lines[1] ? 32'h8000_0003 : 32'h8000_0007);
        check("interrupt_o", 32'(interrupt_o), 32'(lines != 0));
        if (lines != 0) begin
            check("trap_cause_o", trap_cause_o, exp_cause);
        end
    end
    @(negedge clk_i);
    idle_inputs();
    // timer against an illegal instruction in vectored mode
    csr_write(csr_mtvec, 32'h0000_0201);
    @(negedge clk_i);
    irq_timer_i = 1'b1;
    excp_ilgl_i = 1'b1;
    excp_pc_i   = 32'h0000_2000;
    excp_ins_i  = 32'hFFFF_FFFF;
    ex_valid_i  = 1'b1;
    wait_jump(4);
    check("trap_cause_o", trap_cause_o, 32'h8000_0007);
    check("trap_entry_addr_o", trap_entry_addr_o, 32'h0000_021C);
    @(negedge clk_i);
    idle_inputs();
    read_check(csr_mcause, "mcause", 32'h8000_0007);
    read_check(csr_mepc, "mepc", 32'h0000_2000);
    read_check(csr_mtval, "mtval", 32'd0);
    // software interrupt raised through mip
    csr_write(csr_mstatus, 32'h0000_0008);
    csr_write(csr_mip, 32'h0000_0008);
    #10;
    check("interrupt_o", 32'(interrupt_o), 32'd1);
    check("trap_cause_o", trap_cause_o, 32'h8000_0003);
    check("trap_entry_addr_o", trap_entry_addr_o, 32'h0000_020C);
    read_check(csr_mip, "mip", 32'h0000_0008);
    csr_write(csr_mip, 32'd0);
    csr_write(csr_mie, 32'd0);
    csr_write(csr_mstatus, 32'd0);
    csr_write(csr_mtvec, 32'h0000_0100);
    finish_test("interrupts", start);
endtask

task automatic test_mret_user_mode();
    int    start;
    word_t d;
    start = errors;
    csr_write(csr_mepc, 32'h0000_0400);
    csr_write(csr_mstatus, 32'h0000_0080);
    do_mret(32'h0000_0400);
    check("mode_o", 32'(mode_o), 32'd0);
    csr_read(csr_mstatus, d);
    check("priv_too_low_o", 32'(priv_too_low_o), 32'd1);
    check("mstatus", d, 32'h0000_0088);
    // ecall from user mode
    @(negedge clk_i);
    excp_ecall_i = 1'b1;
    excp_pc_i    = 32'h0000_0404;
    ex_valid_i   = 1'b1;
    wait_jump(4);
    check("trap_cause_o", trap_cause_o, 32'd8);
    @(negedge clk_i);
    idle_inputs();
    check("mode_o", 32'(mode_o), 32'd3);
    read_check(csr_mstatus, "mstatus", 32'h0000_0080);
    // back to user with MIE clear where external is still taken
    csr_write(csr_mstatus, 32'd0);
    csr_write(csr_mie, 32'h0000_0800);
    do_mret(32'h0000_0404);
    check("mode_o", 32'(mode_o), 32'd0);
    read_check(csr_mstatus, "mstatus", 32'h0000_0080);
    @(negedge clk_i);
    irq_extern_i = 1'b1;
    excp_pc_i    = 32'h0000_0500;
    ex_valid_i   = 1'b1;
    wait_jump(4);
    check("interrupt_o", 32'(interrupt_o), 32'd1);
    check("trap_cause_o", trap_cause_o, 32'h8000_000B);
    @(negedge clk_i);
    idle_inputs();
    check("mode_o", 32'(mode_o), 32'd3);
    csr_write(csr_mie, 32'd0);
    finish_test("mret_user_mode", start);
endtask

/* dv/rv_trap_tb.sv */
// --------------------------------------------------
// testbench for the trap and CSR unit
// --------------------------------------------------
`default_nettype none

module rv_trap_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_trap_pkg::*;

    logic       clk_i = 1'b0;
    logic       reset_i;
    logic       exs_en_i;
    logic       access_i;
    csr_addr_t  addr_i;
    word_t      rd_data_o;
    logic       bad_csr_addr_o;
    logic       readonly_csr_o;
    logic       priv_too_low_o;
    logic       wr_i;
    csr_addr_t  wr_addr_i;
    word_t      wr_data_i;
    logic       irq_extern_i;
    logic       irq_softw_i;
    logic       irq_timer_i;
    logic       ex_valid_i;
    logic       excp_ferr_i;
    logic       excp_ilgl_i;
    logic       excp_maif_i;
    logic       excp_mala_i;
    logic       excp_masa_i;
    logic       excp_ecall_i;
    word_t      excp_pc_i;
    word_t      excp_ins_i;
    logic       interrupt_o;
    logic       jump_to_trap_o;
    word_t      trap_entry_addr_o;
    logic       trap_rtn_i;
    word_t      trap_rtn_addr_o;
    word_t      trap_cause_o;
    priv_mode_e mode_o;

    int     errors = 0;
    int     checks = 0;
    int     tests  = 0;
    integer seed   = 69;

    rv_trap_top dut_i (.*);

    always #50 clk_i = ~clk_i;

    task automatic check(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    // everything quiet, pipeline running
    task automatic idle_inputs();
        exs_en_i   = 1'b1;
        access_i   = 1'b0;
        addr_i     = '0;
        wr_i       = 1'b0;
        wr_addr_i  = '0;
        wr_data_i  = '0;
        ex_valid_i = 1'b0;
        trap_rtn_i = 1'b0;
        excp_pc_i  = '0;
        excp_ins_i = '0;
        {irq_extern_i, irq_softw_i, irq_timer_i} = 3'b000;
        {excp_ferr_i, excp_ilgl_i, excp_maif_i, excp_mala_i, excp_masa_i, excp_ecall_i} = '0;
    endtask

    task automatic csr_write(input csr_addr_t addr, input word_t data);
        @(negedge clk_i);
        wr_i      = 1'b1;
        wr_addr_i = addr;
        wr_data_i = data;
        @(negedge clk_i);
        wr_i = 1'b0;
    endtask

    // read result is registered, so it is ready one edge later
    task automatic csr_read(input csr_addr_t addr, output word_t data);
        @(negedge clk_i);
        access_i = 1'b1;
        addr_i   = addr;
        @(negedge clk_i);
        access_i = 1'b0;
        data     = rd_data_o;
    endtask

    task automatic read_check(input csr_addr_t addr, input string name, input word_t expected);
        word_t data;
        csr_read(addr, data);
        check(name, data, expected);
    endtask

    task automatic wait_jump(input int limit);
        int n;
        n = 0;
        #10;
        while (jump_to_trap_o !== 1'b1 && n < limit) begin
            @(negedge clk_i);
            #10;
            n++;
        end
        if (jump_to_trap_o !== 1'b1) begin
            $display("timeout: jump_to_trap_o did not rise within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int start);
        tests++;
        $display("test %-18s %s", name, (errors == start) ? "passed" : "failed");
    endtask

    `include "rv_trap_tests.svh"

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        reset_i = 1'b1;
        idle_inputs();
        repeat (8) @(negedge clk_i);
        reset_i = 1'b0;
        test_reset_state();
        test_register_access();
        test_exception_trap();
        test_interrupts();
        test_mret_user_mode();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/csr_state_if.sv */
// --------------------------------------------------
// live machine state, CSR file to trap units
// --------------------------------------------------
`default_nettype none

interface csr_state_if;
    import rv_trap_pkg::*;

    priv_mode_e mode;
    logic       mstatus_mie;
    irq_vec_t   mie;
    irq_vec_t   mip;

    modport owner (
        output mode, mstatus_mie, mie, mip
    );

    modport irq_view (
        input mode, mstatus_mie, mie, mip
    );

    // exceptions only care about the mode for ecall
    modport excp_view (
        input mode
    );

endinterface

`default_nettype wire

/* logic/excp_unit.sv */
// --------------------------------------------------
// exception unit: picks the highest priority
// exception, encodes its cause and trap value
// --------------------------------------------------
`default_nettype none

module excp_unit (
    input  logic                   excp_ferr_i,
    input  logic                   excp_ilgl_i,
    input  logic                   excp_maif_i,
    input  logic                   excp_mala_i,
    input  logic                   excp_masa_i,
    input  logic                   excp_ecall_i,
    input  rv_trap_pkg::word_t     excp_pc_i,
    input  rv_trap_pkg::word_t     excp_ins_i,
    csr_state_if.excp_view         state_if,
    output rv_trap_pkg::trap_req_t excp_req_o
);
    import rv_trap_pkg::*;

    word_t ecall_cause;

    assign ecall_cause = (state_if.mode == mode_user) ? CAUSE_ECALL_U : CAUSE_ECALL_M;

    // --------------------------------------------------
    // cause and tval select
    // --------------------------------------------------
    always_comb begin
        excp_req_o.valid = 1'b1;
        excp_req_o.tval  = '0;
        if (excp_ferr_i) begin
            excp_req_o.cause = CAUSE_FETCH_FAULT;
        end else if (excp_ilgl_i) begin
            // offending instruction word goes to mtval
            excp_req_o.cause = CAUSE_ILLEGAL;
            excp_req_o.tval  = excp_ins_i;
        end else if (excp_maif_i) begin
            excp_req_o.cause = CAUSE_MISALIGNED_FETCH;
            excp_req_o.tval  = excp_pc_i;
        end else if (excp_mala_i) begin
            excp_req_o.cause = CAUSE_MISALIGNED_LOAD;
            excp_req_o.tval  = excp_pc_i;
        end else if (excp_masa_i) begin
            excp_req_o.cause = CAUSE_MISALIGNED_STORE;
            excp_req_o.tval  = excp_pc_i;
        end else if (excp_ecall_i) begin
            excp_req_o.cause = ecall_cause;
        end else begin
            excp_req_o.valid = 1'b0;
            excp_req_o.cause = '0;
        end
    end

endmodule

`default_nettype wire

/* logic/irq_unit.sv */
// --------------------------------------------------
// interrupt unit: pending and enable logic with
// fixed priority cause encoding
// --------------------------------------------------
`default_nettype none

module irq_unit (
    input  logic                  irq_extern_i,
    input  logic                  irq_softw_i,
    input  logic                  irq_timer_i,
    csr_state_if.irq_view         state_if,
    output rv_trap_pkg::trap_req_t irq_req_o
);
    import rv_trap_pkg::*;

    irq_vec_t pending;
    irq_vec_t enabled;
    logic     irq_gate;

    // raw lines land on the same bits as mip
    assign pending = {irq_extern_i, 3'b000, irq_timer_i, 3'b000, irq_softw_i, 3'b000}
                   | state_if.mip;

    // user mode always takes machine interrupts
    assign irq_gate = (state_if.mode == mode_user) || state_if.mstatus_mie;
    assign enabled  = irq_gate ? (pending & state_if.mie) : '0;

    // --------------------------------------------------
    // priority: external, software, timer
    // --------------------------------------------------
    always_comb begin
        irq_req_o.valid = 1'b1;
        irq_req_o.tval  = '0;
        if (enabled[11]) begin
            irq_req_o.cause = IRQ_CAUSE_MEXT;
        end else if (enabled[3]) begin
            irq_req_o.cause = IRQ_CAUSE_MSW;
        end else if (enabled[7]) begin
            irq_req_o.cause = IRQ_CAUSE_MTIMER;
        end else begin
            irq_req_o.valid = 1'b0;
            irq_req_o.cause = '0;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_trap_pkg.sv */
// --------------------------------------------------
// shared types and constants for the machine-level
// trap and CSR unit
// --------------------------------------------------
`default_nettype none

package rv_trap_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [11:0]     csr_addr_t;

    // interrupt bit vector, same layout as mie and mip
    typedef logic [11:0]     irq_vec_t;

    typedef enum logic [1:0] {
        mode_user    = 2'd0,
        mode_machine = 2'd3
    } priv_mode_e;

    // --------------------------------------------------
    // implemented CSR addresses
    // --------------------------------------------------
    typedef enum logic [11:0] {
        csr_mstatus   = 12'h300,
        csr_misa      = 12'h301,
        csr_mie       = 12'h304,
        csr_mtvec     = 12'h305,
        csr_mscratch  = 12'h340,
        csr_mepc      = 12'h341,
        csr_mcause    = 12'h342,
        csr_mtval     = 12'h343,
        csr_mip       = 12'h344,
        csr_mvendorid = 12'hF11,
        csr_marchid   = 12'hF12,
        csr_mimpid    = 12'hF13,
        csr_mhartid   = 12'hF14
    } csr_addr_e;

    // --------------------------------------------------
    // cause codes
    // --------------------------------------------------
    localparam word_t CAUSE_MISALIGNED_FETCH = 32'd0;
    localparam word_t CAUSE_FETCH_FAULT      = 32'd1;
    localparam word_t CAUSE_ILLEGAL          = 32'd2;
    localparam word_t CAUSE_MISALIGNED_LOAD  = 32'd4;
    localparam word_t CAUSE_MISALIGNED_STORE = 32'd6;
    localparam word_t CAUSE_ECALL_U          = 32'd8;
    localparam word_t CAUSE_ECALL_M          = 32'd11;

    // interrupt causes carry bit 31
    localparam word_t IRQ_CAUSE_MSW    = 32'h8000_0003;
    localparam word_t IRQ_CAUSE_MTIMER = 32'h8000_0007;
    localparam word_t IRQ_CAUSE_MEXT   = 32'h8000_000B;

    // --------------------------------------------------
    // mstatus fields and write masks
    // --------------------------------------------------
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;
    localparam int MSTATUS_MPP_HI = 12;

    localparam word_t    MSTATUS_WR_MASK = 32'h0000_1888;
    localparam irq_vec_t MIE_WR_MASK     = 12'h888;
    localparam irq_vec_t MIP_WR_MASK     = 12'h888;

    // combinational trap request from the interrupt or exception side
    typedef struct packed {
        logic  valid;
        word_t cause;
        word_t tval;
    } trap_req_t;

endpackage

`default_nettype wire

/* logic/rv_trap_top.sv */
// --------------------------------------------------
// trap and CSR unit top level
// --------------------------------------------------
`default_nettype none

module rv_trap_top #(
    parameter rv_trap_pkg::word_t RESET_VECTOR = 32'h0000_0100,
    parameter rv_trap_pkg::word_t VENDOR_ID    = 32'h0000_0000,
    parameter rv_trap_pkg::word_t ARCH_ID      = 32'h0000_0000,
    parameter rv_trap_pkg::word_t IMPL_ID      = 32'h0000_0000,
    parameter rv_trap_pkg::word_t HART_ID      = 32'h0000_0000
) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    exs_en_i,
    // CSR access and write-back
    input  logic                    access_i,
    input  rv_trap_pkg::csr_addr_t  addr_i,
    output rv_trap_pkg::word_t      rd_data_o,
    output logic                    bad_csr_addr_o,
    output logic                    readonly_csr_o,
    output logic                    priv_too_low_o,
    input  logic                    wr_i,
    input  rv_trap_pkg::csr_addr_t  wr_addr_i,
    input  rv_trap_pkg::word_t      wr_data_i,
    // interrupt lines
    input  logic                    irq_extern_i,
    input  logic                    irq_softw_i,
    input  logic                    irq_timer_i,
    // exceptions
    input  logic                    ex_valid_i,
    input  logic                    excp_ferr_i,
    input  logic                    excp_ilgl_i,
    input  logic                    excp_maif_i,
    input  logic                    excp_mala_i,
    input  logic                    excp_masa_i,
    input  logic                    excp_ecall_i,
    input  rv_trap_pkg::word_t      excp_pc_i,
    input  rv_trap_pkg::word_t      excp_ins_i,
    // trap control
    output logic                    interrupt_o,
    output logic                    jump_to_trap_o,
    output rv_trap_pkg::word_t      trap_entry_addr_o,
    input  logic                    trap_rtn_i,
    output rv_trap_pkg::word_t      trap_rtn_addr_o,
    output rv_trap_pkg::word_t      trap_cause_o,
    output rv_trap_pkg::priv_mode_e mode_o
);
    import rv_trap_pkg::*;

    trap_req_t irq_req;
    trap_req_t excp_req;
    irq_vec_t  irq_lines;

    csr_state_if state_if ();

    // raw lines in mip bit order
    assign irq_lines = {irq_extern_i, 3'b000, irq_timer_i, 3'b000, irq_softw_i, 3'b000};

    irq_unit irq_unit_i (
        .irq_extern_i (irq_extern_i),
        .irq_softw_i  (irq_softw_i),
        .irq_timer_i  (irq_timer_i),
        .state_if     (state_if.irq_view),
        .irq_req_o    (irq_req)
    );

    excp_unit excp_unit_i (
        .excp_ferr_i  (excp_ferr_i),
        .excp_ilgl_i  (excp_ilgl_i),
        .excp_maif_i  (excp_maif_i),
        .excp_mala_i  (excp_mala_i),
        .excp_masa_i  (excp_masa_i),
        .excp_ecall_i (excp_ecall_i),
        .excp_pc_i    (excp_pc_i),
        .excp_ins_i   (excp_ins_i),
        .state_if     (state_if.excp_view),
        .excp_req_o   (excp_req)
    );

    trap_csr_file #(
        .RESET_VECTOR (RESET_VECTOR),
        .VENDOR_ID    (VENDOR_ID),
        .ARCH_ID      (ARCH_ID),
        .IMPL_ID      (IMPL_ID),
        .HART_ID      (HART_ID)
    ) trap_csr_file_i (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .exs_en_i          (exs_en_i),
        .access_i          (access_i),
        .addr_i            (addr_i),
        .wr_addr_i         (wr_addr_i),
        .wr_i              (wr_i),
        .wr_data_i         (wr_data_i),
        .rd_data_o         (rd_data_o),
        .bad_csr_addr_o    (bad_csr_addr_o),
        .readonly_csr_o    (readonly_csr_o),
        .priv_too_low_o    (priv_too_low_o),
        .irq_lines_i       (irq_lines),
        .irq_req_i         (irq_req),
        .excp_req_i        (excp_req),
        .ex_valid_i        (ex_valid_i),
        .excp_pc_i         (excp_pc_i),
        .trap_rtn_i        (trap_rtn_i),
        .interrupt_o       (interrupt_o),
        .jump_to_trap_o    (jump_to_trap_o),
        .trap_entry_addr_o (trap_entry_addr_o),
        .trap_rtn_addr_o   (trap_rtn_addr_o),
        .trap_cause_o      (trap_cause_o),
        .mode_o            (mode_o),
        .state_if          (state_if.owner)
    );

endmodule

`default_nettype wire

/* logic/trap_csr_file.sv */
// --------------------------------------------------
// machine CSR file: register access, trap entry,
// mret and trap target selection
// --------------------------------------------------
`default_nettype none

module trap_csr_file #(
    parameter rv_trap_pkg::word_t RESET_VECTOR = 32'h0000_0100,
    parameter rv_trap_pkg::word_t VENDOR_ID    = 32'h0000_0000,
    parameter rv_trap_pkg::word_t ARCH_ID      = 32'h0000_0000,
    parameter rv_trap_pkg::word_t IMPL_ID      = 32'h0000_0000,
    parameter rv_trap_pkg::word_t HART_ID      = 32'h0000_0000
) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    exs_en_i,
    input  logic                    access_i,
    input  rv_trap_pkg::csr_addr_t  addr_i,
    input  rv_trap_pkg::csr_addr_t  wr_addr_i,
    input  logic                    wr_i,
    input  rv_trap_pkg::word_t      wr_data_i,
    output rv_trap_pkg::word_t      rd_data_o,
    output logic                    bad_csr_addr_o,
    output logic                    readonly_csr_o,
    output logic                    priv_too_low_o,
    input  rv_trap_pkg::irq_vec_t   irq_lines_i,
    input  rv_trap_pkg::trap_req_t  irq_req_i,
    input  rv_trap_pkg::trap_req_t  excp_req_i,
    input  logic                    ex_valid_i,
    input  rv_trap_pkg::word_t      excp_pc_i,
    input  logic                    trap_rtn_i,
    output logic                    interrupt_o,
    output logic                    jump_to_trap_o,
    output rv_trap_pkg::word_t      trap_entry_addr_o,
    output rv_trap_pkg::word_t      trap_rtn_addr_o,
    output rv_trap_pkg::word_t      trap_cause_o,
    output rv_trap_pkg::priv_mode_e mode_o,
    csr_state_if.owner              state_if
);
    import rv_trap_pkg::*;

    priv_mode_e mode_q;
    word_t      mstatus_q;
    irq_vec_t   mie_q;
    irq_vec_t   mip_q;
    word_t      mtvec_q;
    word_t      mscratch_q;
    word_t      mepc_q;
    word_t      mcause_q;
    word_t      mtval_q;

    word_t      trap_cause;
    word_t      trap_tval;
    word_t      trap_base;
    word_t      rd_data;
    logic       rd_bad;
    word_t      mstatus_wr;

    // --------------------------------------------------
    // state toward the trap units
    // --------------------------------------------------
    assign state_if.mode        = mode_q;
    assign state_if.mstatus_mie = mstatus_q[MSTATUS_MIE];
    assign state_if.mie         = mie_q;
    assign state_if.mip         = mip_q;
    assign mode_o               = mode_q;

    // --------------------------------------------------
    // trap select, interrupt wins
    // --------------------------------------------------
    assign interrupt_o    = irq_req_i.valid;
    assign jump_to_trap_o = ex_valid_i & (irq_req_i.valid | excp_req_i.valid);
    assign trap_cause     = irq_req_i.valid ? irq_req_i.cause : excp_req_i.cause;
    assign trap_tval      = irq_req_i.valid ? irq_req_i.tval : excp_req_i.tval;
    assign trap_cause_o   = trap_cause;

    assign trap_base = {mtvec_q[XLEN-1:2], 2'b00};

    // vectored mode only applies to interrupts
    assign trap_entry_addr_o = (mtvec_q[0] && irq_req_i.valid)
                             ? trap_base + {irq_req_i.cause[XLEN-3:0], 2'b00}
                             : trap_base;
    assign trap_rtn_addr_o   = mepc_q;

    // --------------------------------------------------
    // read decode
    // --------------------------------------------------
    always_comb begin
        rd_data = '0;
        rd_bad  = 1'b0;
        case (addr_i)
            csr_mstatus:   rd_data = mstatus_q;
            csr_misa:      rd_data = '0;
            csr_mie:       rd_data = {20'h0_0000, mie_q};
            csr_mtvec:     rd_data = mtvec_q;
            csr_mscratch:  rd_data = mscratch_q;
            csr_mepc:      rd_data = mepc_q;
            csr_mcause:    rd_data = mcause_q;
            csr_mtval:     rd_data = mtval_q;
            csr_mip:       rd_data = {20'h0_0000, mip_q | irq_lines_i};
            csr_mvendorid: rd_data = VENDOR_ID;
            csr_marchid:   rd_data = ARCH_ID;
            csr_mimpid:    rd_data = IMPL_ID;
            csr_mhartid:   rd_data = HART_ID;
            default:       rd_bad  = 1'b1;
        endcase
    end

    // result and access flags held until the next access
    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            rd_data_o      <= '0;
            bad_csr_addr_o <= 1'b0;
            readonly_csr_o <= 1'b0;
            priv_too_low_o <= 1'b0;
        end else if (exs_en_i && access_i) begin
            rd_data_o      <= rd_data;
            bad_csr_addr_o <= rd_bad;
            readonly_csr_o <= (addr_i[11:10] == 2'b11);
            priv_too_low_o <= (addr_i[9:8] > mode_q);
        end
    end

    // MPP only holds user or machine
    always_comb begin
        mstatus_wr = wr_data_i & MSTATUS_WR_MASK;
        if (wr_data_i[MSTATUS_MPP_HI:MSTATUS_MPP_LO] != 2'b11) begin
            mstatus_wr[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = 2'b00;
        end
    end

    // --------------------------------------------------
    // state update: trap, then mret, then write
    // --------------------------------------------------
    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            mode_q     <= mode_machine;
            mstatus_q  <= '0;
            mie_q      <= '0;
            mip_q      <= '0;
            mtvec_q    <= RESET_VECTOR & 32'hFFFF_FFFC;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else if (exs_en_i) begin
            if (jump_to_trap_o) begin
                mstatus_q[MSTATUS_MPP_HI:MSTATUS_MPP_LO] <= mode_q;
                mstatus_q[MSTATUS_MPIE]                  <= mstatus_q[MSTATUS_MIE];
                mstatus_q[MSTATUS_MIE]                   <= 1'b0;
                mepc_q   <= excp_pc_i;
                mcause_q <= trap_cause;
                mtval_q  <= trap_tval;
                mode_q   <= mode_machine;
            end else if (trap_rtn_i) begin
                mode_q <= priv_mode_e'(mstatus_q[MSTATUS_MPP_HI:MSTATUS_MPP_LO]);
                mstatus_q[MSTATUS_MIE]                   <= mstatus_q[MSTATUS_MPIE];
                mstatus_q[MSTATUS_MPIE]                  <= 1'b1;
                mstatus_q[MSTATUS_MPP_HI:MSTATUS_MPP_LO] <= mode_user;
            end else if (wr_i) begin
                case (wr_addr_i)
                    csr_mstatus:  mstatus_q  <= mstatus_wr;
                    csr_mie:      mie_q      <= wr_data_i[11:0] & MIE_WR_MASK;
                    // mode values above 1 are reserved
                    csr_mtvec:    mtvec_q    <= wr_data_i & 32'hFFFF_FFFD;
                    csr_mscratch: mscratch_q <= wr_data_i;
                    csr_mepc:     mepc_q     <= {wr_data_i[XLEN-1:2], 2'b00};
                    csr_mcause:   mcause_q   <= wr_data_i;
                    csr_mtval:    mtval_q    <= wr_data_i;
                    csr_mip:      mip_q      <= wr_data_i[11:0] & MIP_WR_MASK;
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire
